// File: core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// first fetch address after reset.
`define RESET_PC    32'h0000_0000
`define MTVEC_RESET 32'h0000_0100  // trap vector until software moves it.

`define NUM_REGS    32

// machine CSR addresses the core implements.
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341

`endif

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
} opcode_t;

// funct3 of the conditional branches.
typedef enum logic [2:0] {
    F3_BEQ = 3'b000,
    F3_BNE = 3'b001,
    F3_BLT = 3'b100,
    F3_BGE = 3'b101
} branch_f3_t;

typedef enum logic [2:0] {
    F3_PRIV  = 3'b000,  // ECALL and MRET, told apart by bits 31:20.
    F3_CSRRW = 3'b001
} system_f3_t;

typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
} r_fmt_t;

typedef struct packed {
    logic [11:0] imm;  // also the CSR address and the SYSTEM function code.
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
} i_fmt_t;

// B and J formats scatter their immediate bits across the word.
typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_t    opcode;
} b_fmt_t;

typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
} j_fmt_t;

typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    j_fmt_t j;
} instr_u;

endpackage

`default_nettype wire

// File: core_pkg.sv
`default_nettype none

package core_pkg;

// control-flow class carried by each instruction.
typedef enum logic [1:0] {
    PC_NONE,
    PC_JAL,
    PC_JALR,
    PC_BRANCH
} pc_source_t;

typedef enum logic [1:0] {
    NPC_P_4,
    NPC_JUMP,      // target resolved in ID.
    NPC_BRANCH,    // target resolved in EX.
    NPC_EXCEPTION
} next_pc_mux_t;

typedef enum logic {
    EXCPC_MTVEC,
    EXCPC_MEPC
} exc_pc_mux_t;

// result written back by EX.
typedef enum logic [1:0] {
    ALU_ADD,
    ALU_PASS_PC4,  // link value of JAL and JALR.
    ALU_CSR,       // old CSR value of CSRRW.
    ALU_NONE
} alu_op_t;

endpackage

`default_nettype wire

// File: fetch_stage.sv
`default_nettype none

`include "core_consts.svh"

module fetch_stage (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [31:0] next_pc_i,
    input  logic        redirect_i,
    output logic [31:0] imem_addr_o,
    input  logic [31:0] imem_rdata_i,
    output logic        if_valid_o,
    output logic [31:0] if_pc_o,
    output logic [31:0] if_instr_o
);

logic [31:0] pc_q;

assign imem_addr_o = pc_q;  // memory answers in the same cycle.

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        pc_q       <= `RESET_PC;
        if_valid_o <= 1'b0;
    end else begin
        pc_q       <= next_pc_i;
        // the word read while a redirect is chosen is on the wrong path.
        if_valid_o <= ~redirect_i;
    end
end

// the fetched word moves on to decode with its address.
always_ff @(posedge clk_i) begin
    if_pc_o    <= pc_q;
    if_instr_o <= imem_rdata_i;
end

endmodule

`default_nettype wire

// File: decode_stage.sv
`default_nettype none

`include "core_consts.svh"

module decode_stage import isa_pkg::*, core_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        if_valid_i,
    input  logic [31:0] if_pc_i,
    input  logic [31:0] if_instr_i,
    input  logic        flush_i,
    input  logic        wb_we_i,
    input  logic [4:0]  wb_rd_i,
    input  logic [31:0] wb_data_i,
    output logic        id_valid_o,
    output logic [31:0] id_pc_o,
    output logic [31:0] rs1_val_o,
    output logic [31:0] rs2_val_o,
    output logic [31:0] imm_o,
    output logic [4:0]  rd_o,
    output alu_op_t     alu_op_o,
    output logic [2:0]  funct3_o,
    output pc_source_t  pc_source_ex_o,
    output logic [11:0] csr_addr_o,
    output pc_source_t  pc_source_id_o,
    output logic [31:0] jump_target_id_o,
    output logic        trap_id_o,
    output logic        is_mret_o
);

instr_u      instr;
logic [31:0] regs [`NUM_REGS];
logic [31:0] rs1_fwd;
logic [31:0] rs2_fwd;
logic [31:0] imm_itype;
logic [31:0] imm_btype;
logic [31:0] imm_jtype;
logic [31:0] imm_sel;
alu_op_t     alu_op;
pc_source_t  pc_source;
logic        use_imm;
logic        illegal;
logic        is_ecall;
logic        is_mret;
logic        active;

assign instr  = if_instr_i;
assign active = if_valid_i & ~flush_i;  // an EX redirect kills the word in ID.

assign imm_itype = {{20{instr.i.imm[11]}}, instr.i.imm};
assign imm_btype = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
assign imm_jtype = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

// a write retiring in EX this cycle is seen by the read in ID.
function automatic logic [31:0] read_src(input logic [4:0] idx);
    if (idx == 5'd0) begin
        return 32'd0;
    end else if (wb_we_i && (wb_rd_i == idx)) begin
        return wb_data_i;
    end
    return regs[idx];
endfunction

always_comb begin
    rs1_fwd = read_src(instr.r.rs1);
    rs2_fwd = read_src(instr.r.rs2);
end

always_comb begin
    alu_op    = ALU_NONE;
    pc_source = PC_NONE;
    imm_sel   = imm_itype;
    use_imm   = 1'b0;
    illegal   = 1'b0;
    is_ecall  = 1'b0;
    is_mret   = 1'b0;
    case (instr.r.opcode)
        OPC_OP_IMM: begin
            alu_op  = ALU_ADD;
            use_imm = 1'b1;
        end
        OPC_OP: alu_op = ALU_ADD;
        OPC_JAL: begin
            alu_op    = ALU_PASS_PC4;
            pc_source = PC_JAL;
            imm_sel   = imm_jtype;
        end
        OPC_JALR: begin
            alu_op    = ALU_PASS_PC4;
            pc_source = PC_JALR;
        end
        OPC_BRANCH: begin
            pc_source = PC_BRANCH;
            imm_sel   = imm_btype;
        end
        OPC_SYSTEM: begin
            if (instr.i.funct3 == F3_CSRRW) begin
                alu_op  = ALU_CSR;
                illegal = !(instr.i.imm inside {`CSR_MTVEC, `CSR_MEPC});
            end else if (instr.i.funct3 == F3_PRIV && instr.i.imm == 12'h000) begin
                is_ecall = 1'b1;
            end else if (instr.i.funct3 == F3_PRIV && instr.i.imm == 12'h302) begin
                is_mret = 1'b1;
            end else begin
                illegal = 1'b1;
            end
        end
        default: illegal = 1'b1;
    endcase
end

assign pc_source_id_o   = active ? pc_source : PC_NONE;
assign trap_id_o        = active & (illegal | is_ecall);
assign is_mret_o        = active & is_mret;
assign jump_target_id_o = (pc_source == PC_JALR) ? ((rs1_fwd + imm_itype) & ~32'd1)
                                                 : (if_pc_i + imm_jtype);

always_ff @(posedge clk_i) begin
    if (wb_we_i && (wb_rd_i != 5'd0)) begin
        regs[wb_rd_i] <= wb_data_i;
    end
end

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        id_valid_o <= 1'b0;
    end else begin
        id_valid_o <= active & ~trap_id_o;  // a trapped word never reaches EX.
    end
end

always_ff @(posedge clk_i) begin
    id_pc_o        <= if_pc_i;
    rs1_val_o      <= rs1_fwd;
    rs2_val_o      <= use_imm ? imm_itype : rs2_fwd;
    imm_o          <= imm_sel;
    rd_o           <= instr.r.rd;
    alu_op_o       <= alu_op;
    funct3_o       <= instr.r.funct3;
    pc_source_ex_o <= pc_source;
    csr_addr_o     <= instr.i.imm;
end

// an illegal or ECALL word carries no jump of its own.
trap_vs_jump: assert property (@(posedge clk_i) disable iff (rst_i)
    trap_id_o |-> !(pc_source_id_o inside {PC_JAL, PC_JALR}));

endmodule

`default_nettype wire

// File: execute_stage.sv
`default_nettype none

module execute_stage import isa_pkg::*, core_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        id_valid_i,
    input  logic [31:0] id_pc_i,
    input  logic [31:0] rs1_val_i,
    input  logic [31:0] rs2_val_i,
    input  logic [31:0] imm_i,
    input  logic [4:0]  rd_i,
    input  alu_op_t     alu_op_i,
    input  logic [2:0]  funct3_i,
    input  pc_source_t  pc_source_i,
    input  logic [11:0] csr_addr_i,
    input  logic        flush_i,
    input  logic [31:0] csr_rdata_i,
    output logic        branch_decision_ex_o,
    output logic [31:0] branch_target_ex_o,
    output logic        trap_ex_o,
    output logic        wb_we_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o,
    output logic        csr_we_o,
    output logic [11:0] csr_addr_o,
    output logic [31:0] csr_wdata_o,
    output logic        retire_valid_o,
    output logic [31:0] retire_pc_o,
    output logic [4:0]  retire_rd_o,
    output logic [31:0] retire_data_o
);

logic [31:0] target_sum;
logic [31:0] target;
logic        taken;
logic        is_jump;

// JALR adds to rs1, every other target is relative to the PC.
assign target_sum = ((pc_source_i == PC_JALR) ? rs1_val_i : id_pc_i) + imm_i;
assign target     = (pc_source_i == PC_JALR) ? (target_sum & ~32'd1) : target_sum;
assign is_jump    = (pc_source_i == PC_JAL) || (pc_source_i == PC_JALR);

always_comb begin
    case (funct3_i)
        F3_BEQ:  taken = (rs1_val_i == rs2_val_i);
        F3_BNE:  taken = (rs1_val_i != rs2_val_i);
        F3_BLT:  taken = ($signed(rs1_val_i) < $signed(rs2_val_i));
        F3_BGE:  taken = ($signed(rs1_val_i) >= $signed(rs2_val_i));
        default: taken = 1'b0;
    endcase
end

assign branch_decision_ex_o = id_valid_i && (pc_source_i == PC_BRANCH) && taken;
assign branch_target_ex_o   = target;

// a jump was redirected in ID already, its alignment is checked here.
assign trap_ex_o = id_valid_i && (target[1:0] != 2'b00) && (branch_decision_ex_o || is_jump);

always_comb begin
    case (alu_op_i)
        ALU_ADD:      wb_data_o = rs1_val_i + rs2_val_i;
        ALU_PASS_PC4: wb_data_o = id_pc_i + 32'd4;
        ALU_CSR:      wb_data_o = csr_rdata_i;
        default:      wb_data_o = 32'd0;
    endcase
end

assign retire_valid_o = id_valid_i & ~trap_ex_o;
assign wb_we_o        = retire_valid_o && (alu_op_i != ALU_NONE);
assign wb_rd_o        = rd_i;

assign csr_we_o    = retire_valid_o && (alu_op_i == ALU_CSR);
assign csr_addr_o  = csr_addr_i;
assign csr_wdata_o = rs1_val_i;  // CSRRW writes rs1 unchanged.

assign retire_pc_o   = id_pc_i;
assign retire_rd_o   = wb_we_o ? rd_i : 5'd0;
assign retire_data_o = wb_data_o;

retire_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    retire_valid_o |-> id_valid_i);

// after our own redirect, decode must not hand over the younger word.
flush_empties_ex: assert property (@(posedge clk_i) disable iff (rst_i)
    flush_i |=> !id_valid_i);

endmodule

`default_nettype wire

// File: csr_unit.sv
`default_nettype none

`include "core_consts.svh"

module csr_unit (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        csr_we_i,
    input  logic [11:0] csr_addr_i,
    input  logic [31:0] csr_wdata_i,
    input  logic        trap_id_i,
    input  logic        trap_ex_i,
    input  logic [31:0] id_pc_i,
    input  logic [31:0] ex_pc_i,
    output logic [31:0] csr_rdata_o,
    output logic [31:0] mtvec_o,
    output logic [31:0] mepc_o
);

logic [31:0] mtvec_q;
logic [31:0] mepc_q;
logic        wr_mtvec;
logic        wr_mepc;

assign wr_mtvec = csr_we_i && (csr_addr_i == `CSR_MTVEC);
assign wr_mepc  = csr_we_i && (csr_addr_i == `CSR_MEPC);

// CSRRW hands back the value from before its own write.
always_comb begin
    case (csr_addr_i)
        `CSR_MTVEC: csr_rdata_o = mtvec_q;
        `CSR_MEPC:  csr_rdata_o = mepc_q;
        default:    csr_rdata_o = 32'd0;
    endcase
end

// an MRET or trap in ID right behind a CSRRW sees the new value.
assign mtvec_o = wr_mtvec ? csr_wdata_i : mtvec_q;
assign mepc_o  = wr_mepc ? csr_wdata_i : mepc_q;

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        mtvec_q <= `MTVEC_RESET;
        mepc_q  <= 32'd0;
    end else begin
        if (trap_ex_i) begin
            mepc_q <= ex_pc_i;  // the older instruction wins.
        end else if (trap_id_i) begin
            mepc_q <= id_pc_i;
        end else if (wr_mepc) begin
            mepc_q <= csr_wdata_i;
        end
        if (wr_mtvec) begin
            mtvec_q <= csr_wdata_i;
        end
    end
end

endmodule

`default_nettype wire

// File: pc_controller.sv
`default_nettype none

module pc_controller import core_pkg::*; #(
    parameter int WIDTH = 32
) (
    output logic [WIDTH-1:0] next_pc_o,
    output logic             redirect_o,
    input  logic [WIDTH-1:0] curr_pc_i,
    input  logic [WIDTH-1:0] jump_target_id_i,
    input  logic [WIDTH-1:0] branch_target_ex_i,
    input  logic             branch_decision_ex_i,
    input  pc_source_t       pc_source_id_i,
    input  pc_source_t       pc_source_ex_i,
    input  logic             trap_id_i,
    input  logic             trap_ex_i,
    input  logic             is_mret_i,
    input  logic [WIDTH-1:0] mtvec_i,
    input  logic [WIDTH-1:0] mepc_i
);

next_pc_mux_t     next_pc_mux;
exc_pc_mux_t      exc_pc_mux;
logic [WIDTH-1:0] exc_pc;
logic             ex_path;
logic             id_path;

assign ex_path = trap_ex_i || ((pc_source_ex_i == PC_BRANCH) && branch_decision_ex_i);
assign id_path = trap_id_i || is_mret_i ||
                 (pc_source_id_i == PC_JAL) || (pc_source_id_i == PC_JALR);

// EX is older than ID, so its redirect comes first.
always_comb begin
    if (trap_ex_i)
        next_pc_mux = NPC_EXCEPTION;
    else if ((pc_source_ex_i == PC_BRANCH) && branch_decision_ex_i)
        next_pc_mux = NPC_BRANCH;
    else if (trap_id_i || is_mret_i)
        next_pc_mux = NPC_EXCEPTION;
    else if ((pc_source_id_i == PC_JAL) || (pc_source_id_i == PC_JALR))
        next_pc_mux = NPC_JUMP;
    else
        next_pc_mux = NPC_P_4;
end

assign exc_pc_mux = is_mret_i ? EXCPC_MEPC : EXCPC_MTVEC;
assign exc_pc     = (exc_pc_mux == EXCPC_MEPC) ? mepc_i : mtvec_i;

always_comb begin
    case (next_pc_mux)
        NPC_JUMP:      next_pc_o = jump_target_id_i;
        NPC_BRANCH:    next_pc_o = branch_target_ex_i;
        NPC_EXCEPTION: next_pc_o = exc_pc;
        default:       next_pc_o = curr_pc_i + WIDTH'(4);
    endcase
end

assign redirect_o = (next_pc_mux != NPC_P_4);

// decode drops its requests whenever EX redirects.
id_ex_exclusive: assert final (!(ex_path && id_path))
    else $error("ID and EX redirects requested in the same cycle.");

endmodule

`default_nettype wire

// File: core_top.sv
`default_nettype none

module core_top import core_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    output logic [31:0] imem_addr_o,
    input  logic [31:0] imem_rdata_i,
    output logic        retire_valid_o,
    output logic [31:0] retire_pc_o,
    output logic [4:0]  retire_rd_o,
    output logic [31:0] retire_data_o
);

logic        if_valid;
logic [31:0] if_pc;
logic [31:0] if_instr;
logic [31:0] next_pc;
logic        redirect;

logic        id_valid;
logic [31:0] id_pc;
logic [31:0] rs1_val;
logic [31:0] rs2_val;
logic [31:0] imm;
logic [4:0]  rd;
alu_op_t     alu_op;
logic [2:0]  funct3;
pc_source_t  pc_source_ex;
logic [11:0] csr_addr_id;
pc_source_t  pc_source_id;
logic [31:0] jump_target_id;
logic        trap_id;
logic        is_mret;

logic        branch_decision_ex;
logic [31:0] branch_target_ex;
logic        trap_ex;
logic        ex_redirect;
logic        wb_we;
logic [4:0]  wb_rd;
logic [31:0] wb_data;
logic        csr_we;
logic [11:0] csr_addr;
logic [31:0] csr_wdata;
logic [31:0] csr_rdata;
logic [31:0] mtvec;
logic [31:0] mepc;

assign ex_redirect = trap_ex | branch_decision_ex;  // flushes the word in ID.

fetch_stage u_fetch (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .next_pc_i    (next_pc),
    .redirect_i   (redirect),
    .imem_addr_o  (imem_addr_o),
    .imem_rdata_i (imem_rdata_i),
    .if_valid_o   (if_valid),
    .if_pc_o      (if_pc),
    .if_instr_o   (if_instr)
);

decode_stage u_decode (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .if_valid_i       (if_valid),
    .if_pc_i          (if_pc),
    .if_instr_i       (if_instr),
    .flush_i          (ex_redirect),
    .wb_we_i          (wb_we),
    .wb_rd_i          (wb_rd),
    .wb_data_i        (wb_data),
    .id_valid_o       (id_valid),
    .id_pc_o          (id_pc),
    .rs1_val_o        (rs1_val),
    .rs2_val_o        (rs2_val),
    .imm_o            (imm),
    .rd_o             (rd),
    .alu_op_o         (alu_op),
    .funct3_o         (funct3),
    .pc_source_ex_o   (pc_source_ex),
    .csr_addr_o       (csr_addr_id),
    .pc_source_id_o   (pc_source_id),
    .jump_target_id_o (jump_target_id),
    .trap_id_o        (trap_id),
    .is_mret_o        (is_mret)
);

execute_stage u_execute (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .id_valid_i           (id_valid),
    .id_pc_i              (id_pc),
    .rs1_val_i            (rs1_val),
    .rs2_val_i            (rs2_val),
    .imm_i                (imm),
    .rd_i                 (rd),
    .alu_op_i             (alu_op),
    .funct3_i             (funct3),
    .pc_source_i          (pc_source_ex),
    .csr_addr_i           (csr_addr_id),
    .flush_i              (ex_redirect),
    .csr_rdata_i          (csr_rdata),
    .branch_decision_ex_o (branch_decision_ex),
    .branch_target_ex_o   (branch_target_ex),
    .trap_ex_o            (trap_ex),
    .wb_we_o              (wb_we),
    .wb_rd_o              (wb_rd),
    .wb_data_o            (wb_data),
    .csr_we_o             (csr_we),
    .csr_addr_o           (csr_addr),
    .csr_wdata_o          (csr_wdata),
    .retire_valid_o       (retire_valid_o),
    .retire_pc_o          (retire_pc_o),
    .retire_rd_o          (retire_rd_o),
    .retire_data_o        (retire_data_o)
);

csr_unit u_csr (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .csr_we_i    (csr_we),
    .csr_addr_i  (csr_addr),
    .csr_wdata_i (csr_wdata),
    .trap_id_i   (trap_id),
    .trap_ex_i   (trap_ex),
    .id_pc_i     (if_pc),
    .ex_pc_i     (id_pc),
    .csr_rdata_o (csr_rdata),
    .mtvec_o     (mtvec),
    .mepc_o      (mepc)
);

pc_controller u_pc_ctrl (
    .next_pc_o            (next_pc),
    .redirect_o           (redirect),
    .curr_pc_i            (imem_addr_o),
    .jump_target_id_i     (jump_target_id),
    .branch_target_ex_i   (branch_target_ex),
    .branch_decision_ex_i (branch_decision_ex),
    .pc_source_id_i       (pc_source_id),
    .pc_source_ex_i       (pc_source_ex),
    .trap_id_i            (trap_id),
    .trap_ex_i            (trap_ex),
    .is_mret_i            (is_mret),
    .mtvec_i              (mtvec),
    .mepc_i               (mepc)
);

endmodule

`default_nettype wire

// File: tb_core.sv
`default_nettype none

`include "core_consts.svh"

module tb_core;

localparam int RESET_CYCLES    = 10;
localparam int CYCLES_PER_TEST = 40;
localparam int NUM_TESTS       = 5;
localparam int MAX_CYCLES      = NUM_TESTS * (RESET_CYCLES + CYCLES_PER_TEST);
localparam int MEM_WORDS       = 256;

localparam logic [31:0] TRAP_VEC   = `MTVEC_RESET;
localparam logic [31:0] ECALL_WORD = 32'h0000_0073;
localparam logic [31:0] MRET_WORD  = 32'h3020_0073;

logic        clk;
logic        rst;
logic [31:0] imem_addr;
logic [31:0] imem_rdata;
logic        retire_valid;
logic [31:0] retire_pc;
logic [4:0]  retire_rd;
logic [31:0] retire_data;

logic [31:0] mem [MEM_WORDS];
logic [31:0] fetch_hist [2];  // fetch addresses of the last two cycles, newest first.
integer      seed = 32'h0a980fb4;
int          error_count = 0;
int          cycle_count = 0;

core_top dut (
    .clk_i          (clk),
    .rst_i          (rst),
    .imem_addr_o    (imem_addr),
    .imem_rdata_i   (imem_rdata),
    .retire_valid_o (retire_valid),
    .retire_pc_o    (retire_pc),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data)
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

// instruction memory returns the word at the current fetch address.
always @(negedge clk) begin
    imem_rdata <= mem[imem_addr[9:2]];
end

// a word shown on the fetch address retires two cycles later.
always @(negedge clk) begin
    fetch_hist[0] <= imem_addr;
    fetch_hist[1] <= fetch_hist[0];
end

always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
        $display("TIMEOUT at time %0t: the core stopped retiring within %0d cycles.",
                 $time, MAX_CYCLES);
        $display("Result: FAILED");
        $fatal(1);
    end
end

function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic logic [31:0] add_word(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
endfunction

function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b1100111};
endfunction

function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] csrrw_word(input logic [4:0] rd, input logic [11:0] csr,
                                           input logic [4:0] rs1);
    return {csr, rs1, 3'b001, rd, 7'b1110011};
endfunction

function automatic logic [31:0] sign_extend12(input logic [11:0] value);
    return {{20{value[11]}}, value};
endfunction

// compare rule of BEQ, BNE, BLT and BGE.
function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        default: return 1'b0;
    endcase
endfunction

// funct3, first and second source register of each branch in the branch test.
function automatic logic [12:0] branch_case(input int idx);
    case (idx)
        0:       return {3'b000, 5'd1, 5'd2};
        1:       return {3'b000, 5'd1, 5'd3};
        2:       return {3'b001, 5'd1, 5'd2};
        3:       return {3'b001, 5'd1, 5'd3};
        4:       return {3'b100, 5'd1, 5'd2};
        5:       return {3'b100, 5'd2, 5'd1};
        6:       return {3'b101, 5'd1, 5'd2};
        default: return {3'b101, 5'd1, 5'd3};
    endcase
endfunction

task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    if (actual !== expected) begin
        error_count++;
        $display("ERROR at time %0t: %s is %h, expected %h", $time, what, actual, expected);
        $display("Result: FAILED");
        $fatal(1);
    end
endtask

task automatic place(input logic [31:0] addr, input logic [31:0] word);
    mem[addr[9:2]] = word;
endtask

// unused words hold an ADDI of x0 whose immediate is their own address.
task automatic hold_reset;
    @(negedge clk);
    rst = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] = addi_word(5'd0, 5'd0, 12'(i * 4));
    end
endtask

task automatic release_reset;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
endtask

task automatic next_retire;
    @(negedge clk);
    while (!retire_valid) begin
        @(negedge clk);
    end
endtask

task automatic expect_retire(input logic [31:0] pc, input logic [4:0] rd,
                             input logic [31:0] data);
    next_retire();
    check_equal(retire_pc, pc, "retired pc");
    check_equal(fetch_hist[1], pc, $sformatf("fetch address two cycles before pc %h", pc));
    check_equal({27'd0, retire_rd}, {27'd0, rd}, $sformatf("rd retired by pc %h", pc));
    check_equal(retire_data, data, $sformatf("data retired by pc %h", pc));
endtask

task automatic straight_line_test;
    logic [31:0] rnd;
    logic [11:0] ia;
    logic [11:0] ib;
    logic [31:0] x1;
    logic [31:0] x2;
    logic [31:0] x3;
    logic [31:0] x4;
    rnd = $random(seed);
    ia  = rnd[11:0];
    rnd = $random(seed);
    ib  = rnd[11:0];
    x1  = sign_extend12(ia);
    x2  = x1 + sign_extend12(ib);
    x3  = x1 + x2;
    x4  = x3 + x3;
    hold_reset();
    place(32'h00, addi_word(5'd1, 5'd0, ia));
    place(32'h04, addi_word(5'd2, 5'd1, ib));  // x1 arrives through forwarding.
    place(32'h08, add_word(5'd3, 5'd1, 5'd2));
    place(32'h0c, add_word(5'd4, 5'd3, 5'd3));
    place(32'h10, addi_word(5'd5, 5'd4, 12'hfff));
    place(32'h14, jal_word(5'd0, 21'd0));
    release_reset();
    expect_retire(32'h00, 5'd1, x1);
    expect_retire(32'h04, 5'd2, x2);
    expect_retire(32'h08, 5'd3, x3);
    expect_retire(32'h0c, 5'd4, x4);
    expect_retire(32'h10, 5'd5, x4 - 32'd1);
endtask

task automatic jump_test;
    hold_reset();
    place(32'h00, addi_word(5'd5, 5'd0, 12'h020));
    place(32'h04, jal_word(5'd1, 21'd12));
    place(32'h08, addi_word(5'd9, 5'd0, 12'd1));  // fetched behind the JAL, then dropped.
    place(32'h0c, addi_word(5'd9, 5'd0, 12'd2));
    // bit 0 of the JALR sum is cleared, so the target is 0x24.
    place(32'h10, jalr_word(5'd2, 5'd5, 12'd5));
    place(32'h14, addi_word(5'd9, 5'd0, 12'd3));
    place(32'h24, add_word(5'd3, 5'd1, 5'd2));
    place(32'h28, jal_word(5'd0, 21'd0));
    release_reset();
    expect_retire(32'h00, 5'd5, 32'h20);
    expect_retire(32'h04, 5'd1, 32'h08);
    expect_retire(32'h10, 5'd2, 32'h14);
    expect_retire(32'h24, 5'd3, 32'h1c);
endtask

task automatic branch_test;
    logic [31:0] rnd;
    logic [31:0] xv [4];
    logic [2:0]  f3;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] pc;
    rnd   = $random(seed);
    xv[0] = 32'd0;
    xv[1] = sign_extend12(rnd[11:0]);
    rnd   = $random(seed);
    xv[2] = sign_extend12(rnd[11:0]);
    xv[3] = xv[1];  // an equal pair for BEQ and BNE.
    hold_reset();
    place(32'h00, addi_word(5'd1, 5'd0, xv[1][11:0]));
    place(32'h04, addi_word(5'd2, 5'd0, xv[2][11:0]));
    place(32'h08, addi_word(5'd3, 5'd1, 12'd0));
    // each branch skips a marker ADDI that retires only when it falls through.
    for (int i = 0; i < 8; i++) begin
        {f3, ra, rb} = branch_case(i);
        pc = 32'd12 + 32'(8 * i);
        place(pc, branch_word(f3, ra, rb, 13'd8));
        place(pc + 32'd4, addi_word(5'd10, 5'd0, 12'(i + 1)));
    end
    place(32'h4c, jal_word(5'd0, 21'd0));
    release_reset();
    expect_retire(32'h00, 5'd1, xv[1]);
    expect_retire(32'h04, 5'd2, xv[2]);
    expect_retire(32'h08, 5'd3, xv[3]);
    for (int i = 0; i < 8; i++) begin
        {f3, ra, rb} = branch_case(i);
        pc = 32'd12 + 32'(8 * i);
        expect_retire(pc, 5'd0, 32'd0);
        if (!branch_taken(f3, xv[ra], xv[rb])) begin
            expect_retire(pc + 32'd4, 5'd10, 32'(i + 1));
        end
    end
endtask

task automatic trap_return_test;
    hold_reset();
    place(32'h00, addi_word(5'd1, 5'd0, 12'h040));
    place(32'h04, ECALL_WORD);
    place(32'h08, addi_word(5'd9, 5'd0, 12'd7));
    place(32'h40, csrrw_word(5'd3, `CSR_MEPC, 5'd0));
    place(32'h44, addi_word(5'd4, 5'd0, TRAP_VEC[11:0]));
    place(32'h48, csrrw_word(5'd5, `CSR_MTVEC, 5'd4));
    place(32'h4c, jal_word(5'd0, 21'd0));
    // the handler moves mepc to 0x40 and returns there.
    place(TRAP_VEC, csrrw_word(5'd2, `CSR_MEPC, 5'd1));
    place(TRAP_VEC + 32'd4, MRET_WORD);
    place(TRAP_VEC + 32'd8, addi_word(5'd9, 5'd0, 12'd8));
    release_reset();
    expect_retire(32'h00, 5'd1, 32'h40);
    expect_retire(TRAP_VEC, 5'd2, 32'h04);  // mepc holds the ECALL address.
    expect_retire(TRAP_VEC + 32'd4, 5'd0, 32'd0);
    expect_retire(32'h40, 5'd3, 32'h40);
    expect_retire(32'h44, 5'd4, TRAP_VEC);
    expect_retire(32'h48, 5'd5, TRAP_VEC);
endtask

task automatic misaligned_branch_test;
    hold_reset();
    place(32'h00, addi_word(5'd1, 5'd0, 12'd3));
    place(32'h04, branch_word(3'b000, 5'd0, 5'd0, 13'd6));  // target 0x0a is misaligned.
    place(32'h08, addi_word(5'd9, 5'd0, 12'd1));
    place(32'h0c, addi_word(5'd9, 5'd0, 12'd2));
    place(TRAP_VEC, csrrw_word(5'd2, `CSR_MEPC, 5'd0));
    place(TRAP_VEC + 32'd4, jal_word(5'd0, 21'd0));
    release_reset();
    expect_retire(32'h00, 5'd1, 32'd3);
    expect_retire(TRAP_VEC, 5'd2, 32'h04);
endtask

initial begin
    rst        = 1'b1;
    imem_rdata = 32'd0;
    straight_line_test();
    jump_test();
    branch_test();
    trap_return_test();
    misaligned_branch_test();
    if (error_count == 0) begin
        $display("Result: PASSED");
        $finish;
    end else begin
        $display("Result: FAILED");
        $fatal(1);
    end
end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
isa_pkg.sv
core_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
csr_unit.sv
pc_controller.sv
core_top.sv
tb_core.sv

// File: Bender.yml
package:
  name: rv32_front_end

export_include_dirs:
  - .

sources:
  - isa_pkg.sv
  - core_pkg.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - csr_unit.sv
  - pc_controller.sv
  - core_top.sv
  - target: simulation
    files:
      - tb_core.sv
